// ==== ram_test_pkg.sv ====
// shared types, request and response structs for the RAM tester
// timer, LFSR and seed constants

`default_nettype none

package ram_test_pkg;

  // widths as seen on the RAM ports and inside the generators
  typedef logic [24:0]  mem_addr_t;
  typedef logic [22:0]  gen_addr_t;
  typedef logic [127:0] mem_data_t;
  typedef logic [31:0]  lfsr_t;
  typedef logic [9:0]   op_count_t;

  typedef struct packed {
    logic      stb;
    mem_addr_t addr;
  } inst_req_t;

  typedef struct packed {
    logic      ack;
    mem_data_t rdata;
  } inst_rsp_t;

  typedef struct packed {
    logic      stb;
    logic      we;
    mem_addr_t addr;
    mem_data_t wdata;
  } data_req_t;

  typedef struct packed {
    logic      ack;
    mem_data_t rdata;
  } data_rsp_t;

  // request spacing on each port
  localparam logic [5:0] INST_PERIOD = 6'd37;
  localparam logic [5:0] INST_PHASE  = 6'd19;
  localparam logic [4:0] DATA_PERIOD = 5'd17;
  localparam logic [4:0] DATA_PHASE  = 5'd7;

  localparam lfsr_t LFSR_TAPS    = 32'hD000_0001;
  localparam lfsr_t ADDR_SEED    = 32'hC703_37DB;
  localparam lfsr_t DATA_SEED_HI = 32'h7F4D_514F;
  localparam lfsr_t DATA_SEED_LO = 32'h7537_7599;

endpackage

`default_nettype wire

// ==== adr_data_gen.sv ====
// pseudo-random address and data generator
// one address LFSR and two data LFSRs stepped on request

`timescale 1ns/1ps
`default_nettype none

module adr_data_gen (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    next,
  output ram_test_pkg::gen_addr_t addr,
  output ram_test_pkg::mem_data_t data
);

  ram_test_pkg::lfsr_t addr_lfsr;
  ram_test_pkg::lfsr_t data_hi;
  ram_test_pkg::lfsr_t data_lo;

  // galois step, feedback applied when the dropped bit is one
  function automatic ram_test_pkg::lfsr_t lfsr_step(input ram_test_pkg::lfsr_t s);
    ram_test_pkg::lfsr_t shifted;
    shifted = s >> 1;
    if (s[0]) begin
      shifted = shifted ^ ram_test_pkg::LFSR_TAPS;
    end
    return shifted;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_lfsr <= ram_test_pkg::ADDR_SEED;
      data_hi   <= ram_test_pkg::DATA_SEED_HI;
      data_lo   <= ram_test_pkg::DATA_SEED_LO;
    end else if (next) begin
      addr_lfsr <= lfsr_step(addr_lfsr);
      data_hi   <= lfsr_step(data_hi);
      data_lo   <= lfsr_step(data_lo);
    end
  end

  assign addr = addr_lfsr[22:0];
  // 64 random bits widened to a full word by appending their inverse
  assign data = {data_hi, data_lo, ~data_hi, ~data_lo};

endmodule

`default_nettype wire

// ==== ram_test_ctrl.sv ====
// strobe timers for the instruction and data ports
// write/read scheduling, data operation counter and end of test

`timescale 1ns/1ps
`default_nettype none

module ram_test_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic inst_ack,
  input  logic data_ack,
  output logic inst_stb,
  output logic data_stb,
  output logic data_we,
  output logic test_ended
);

  logic [5:0]              inst_timer;
  logic [4:0]              data_timer;
  ram_test_pkg::op_count_t op_count;

  // instruction port
  always_ff @(posedge clk) begin
    if (rst) begin
      inst_timer <= '0;
      inst_stb   <= 1'b0;
    end else if (inst_stb) begin
      // an outstanding read still completes after the test has ended
      if (inst_ack) begin
        inst_stb <= 1'b0;
      end
    end else if (!test_ended) begin
      if (inst_timer == ram_test_pkg::INST_PERIOD - 6'd1) begin
        inst_timer <= '0;
      end else begin
        inst_timer <= inst_timer + 6'd1;
      end
      if (inst_timer == ram_test_pkg::INST_PHASE) begin
        inst_stb <= 1'b1;
      end
    end
  end

  // data port
  always_ff @(posedge clk) begin
    if (rst) begin
      data_timer <= '0;
      data_stb   <= 1'b0;
      data_we    <= 1'b0;
      op_count   <= '0;
    end else if (data_stb) begin
      if (data_ack) begin
        data_stb <= 1'b0;
        data_we  <= 1'b0;
        op_count <= op_count + 10'd1;
      end
    end else if (!test_ended) begin
      if (data_timer == ram_test_pkg::DATA_PERIOD - 5'd1) begin
        data_timer <= '0;
      end else begin
        data_timer <= data_timer + 5'd1;
      end
      if (data_timer == ram_test_pkg::DATA_PHASE) begin
        data_stb <= 1'b1;
        // every fourth operation reads back
        data_we  <= ~&op_count[1:0];
      end
    end
  end

  // all ones after the last data acknowledge, held since no strobe follows
  assign test_ended = &op_count;

endmodule

`default_nettype wire

// ==== inst_read_path.sv ====
// instruction read datapath
// address generation and sticky compare of returned words

`timescale 1ns/1ps
`default_nettype none

module inst_read_path (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    inst_ack,
  input  ram_test_pkg::mem_data_t inst_rdata,
  output ram_test_pkg::mem_addr_t inst_addr,
  output logic                    inst_error
);

  ram_test_pkg::gen_addr_t ir_addr;
  ram_test_pkg::mem_data_t ir_data;

  // steps once per completed instruction read
  adr_data_gen i_adr_data_gen (
    .clk  (clk),
    .rst  (rst),
    .next (inst_ack),
    .addr (ir_addr),
    .data (ir_data)
  );

  assign inst_addr = ram_test_pkg::mem_addr_t'(ir_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_error <= 1'b0;
    end else if (inst_ack && (inst_rdata != ir_data)) begin
      inst_error <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== data_rw_path.sv ====
// data port datapath
// write and read generators, address select, write data
// sticky compare of data read words

`timescale 1ns/1ps
`default_nettype none

module data_rw_path (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    data_ack,
  input  logic                    data_we,
  input  ram_test_pkg::mem_data_t data_rdata,
  output ram_test_pkg::mem_addr_t data_addr,
  output ram_test_pkg::mem_data_t data_wdata,
  output logic                    data_error
);

  logic                    wr_next;
  logic                    rd_next;
  ram_test_pkg::gen_addr_t wr_addr;
  ram_test_pkg::gen_addr_t rd_addr;
  ram_test_pkg::mem_data_t wr_data;
  ram_test_pkg::mem_data_t rd_data;

  assign wr_next = data_ack & data_we;
  assign rd_next = data_ack & ~data_we;

  adr_data_gen i_wr_gen (
    .clk  (clk),
    .rst  (rst),
    .next (wr_next),
    .addr (wr_addr),
    .data (wr_data)
  );

  // trails the write generator through the same sequence
  adr_data_gen i_rd_gen (
    .clk  (clk),
    .rst  (rst),
    .next (rd_next),
    .addr (rd_addr),
    .data (rd_data)
  );

  assign data_addr  = ram_test_pkg::mem_addr_t'(data_we ? wr_addr : rd_addr);
  assign data_wdata = wr_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_error <= 1'b0;
    end else if (rd_next && (data_rdata != rd_data)) begin
      data_error <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== ram_test_top.sv ====
// top level of the RAM tester
// control, both datapaths and the port structs

`timescale 1ns/1ps
`default_nettype none

module ram_test_top (
  input  logic                    clk,
  input  logic                    rst,
  output ram_test_pkg::inst_req_t inst_req,
  input  ram_test_pkg::inst_rsp_t inst_rsp,
  output ram_test_pkg::data_req_t data_req,
  input  ram_test_pkg::data_rsp_t data_rsp,
  output logic                    test_ended,
  output logic                    test_error
);

  logic inst_stb;
  logic data_stb;
  logic data_we;
  logic inst_error;
  logic data_error;

  ram_test_pkg::mem_addr_t inst_addr;
  ram_test_pkg::mem_addr_t data_addr;
  ram_test_pkg::mem_data_t data_wdata;

  ram_test_ctrl i_ram_test_ctrl (
    .clk        (clk),
    .rst        (rst),
    .inst_ack   (inst_rsp.ack),
    .data_ack   (data_rsp.ack),
    .inst_stb   (inst_stb),
    .data_stb   (data_stb),
    .data_we    (data_we),
    .test_ended (test_ended)
  );

  inst_read_path i_inst_read_path (
    .clk        (clk),
    .rst        (rst),
    .inst_ack   (inst_rsp.ack),
    .inst_rdata (inst_rsp.rdata),
    .inst_addr  (inst_addr),
    .inst_error (inst_error)
  );

  data_rw_path i_data_rw_path (
    .clk        (clk),
    .rst        (rst),
    .data_ack   (data_rsp.ack),
    .data_we    (data_we),
    .data_rdata (data_rsp.rdata),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_error (data_error)
  );

  assign inst_req.stb = inst_stb;
  assign inst_req.addr = inst_addr;

  assign data_req.stb = data_stb;
  assign data_req.we = data_we;
  assign data_req.addr = data_addr;
  assign data_req.wdata = data_wdata;

  // either port mismatching fails the test
  assign test_error = inst_error | data_error;

endmodule

`default_nettype wire

// ==== ram_test_checker.sv ====
// concurrent checks on the strobe and acknowledge protocol of both ports

`timescale 1ns/1ps
`default_nettype none

module ram_test_checker (
  input logic                    clk,
  input logic                    rst,
  input ram_test_pkg::inst_req_t inst_req,
  input ram_test_pkg::inst_rsp_t inst_rsp,
  input ram_test_pkg::data_req_t data_req,
  input ram_test_pkg::data_rsp_t data_rsp,
  input logic                    test_ended
);

  // a request holds until its ack
  inst_hold: assert property (@(posedge clk) disable iff (rst)
    inst_req.stb && !inst_rsp.ack |=> inst_req.stb && $stable(inst_req.addr))
    else $error("instruction request changed before its ack");

  data_hold: assert property (@(posedge clk) disable iff (rst)
    data_req.stb && !data_rsp.ack |=>
      data_req.stb && $stable(data_req.addr) && $stable(data_req.we))
    else $error("data request changed before its ack");

  // once ended, only an open instruction read may still finish
  inst_quiet: assert property (@(posedge clk) disable iff (rst)
    test_ended && !inst_req.stb |=> !inst_req.stb)
    else $error("instruction strobe after the end of the test");

  data_quiet: assert property (@(posedge clk) disable iff (rst)
    test_ended && !data_req.stb |=> !data_req.stb)
    else $error("data strobe after the end of the test");

endmodule

bind ram_test_top ram_test_checker i_ram_test_checker (
  .clk        (clk),
  .rst        (rst),
  .inst_req   (inst_req),
  .inst_rsp   (inst_rsp),
  .data_req   (data_req),
  .data_rsp   (data_rsp),
  .test_ended (test_ended)
);

`default_nettype wire

// ==== tb_ram_test.sv ====
// testbench for the RAM tester
// clock, reset, behavioral dual-port RAM, generator model and directed tests

`timescale 1ns/1ps
`default_nettype none

module tb_ram_test;

  localparam int TIMEOUT   = 40000;
  localparam int MODEL_LEN = 1024;

  logic                    clk = 1'b0;
  logic                    rst;
  ram_test_pkg::inst_req_t inst_req;
  ram_test_pkg::inst_rsp_t inst_rsp;
  ram_test_pkg::data_req_t data_req;
  ram_test_pkg::data_rsp_t data_rsp;
  logic                    test_ended;
  logic                    test_error;

  // RAM model state, cleared while rst is high
  ram_test_pkg::mem_data_t mem [ram_test_pkg::mem_addr_t];
  ram_test_pkg::data_req_t held;
  logic [15:0]             rng;
  int                      inst_wait;
  int                      data_wait;
  int                      inst_count;
  int                      rd_count;
  int                      data_ops;
  int                      hold_errors;
  logic                    stall_seen;
  ram_test_pkg::mem_addr_t wr_addr_q[$];
  ram_test_pkg::mem_data_t wr_data_q[$];
  ram_test_pkg::mem_addr_t rd_addr_q[$];
  ram_test_pkg::mem_addr_t inst_addr_q[$];
  ram_test_pkg::mem_data_t inst_word_q[$];

  // fault injection, -1 disables
  int corrupt_data_rd;
  int corrupt_inst_rd;
  int stall_op;

  ram_test_pkg::mem_addr_t exp_addr [MODEL_LEN];
  ram_test_pkg::mem_data_t exp_word [MODEL_LEN];

  string test_name;
  int    errors = 0;
  int    test_start_errors;
  int    tests_ok = 0;
  int    tests_bad = 0;

  always #5 clk = ~clk;

  ram_test_top i_ram_test_top (
    .clk        (clk),
    .rst        (rst),
    .inst_req   (inst_req),
    .inst_rsp   (inst_rsp),
    .data_req   (data_req),
    .data_rsp   (data_rsp),
    .test_ended (test_ended),
    .test_error (test_error)
  );

  // reference sequence, shift right and fold in the taps when bit 0 drops out
  function automatic ram_test_pkg::lfsr_t model_step(input ram_test_pkg::lfsr_t s);
    return s[0] ? ((s >> 1) ^ ram_test_pkg::LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic build_model();
    ram_test_pkg::lfsr_t a;
    ram_test_pkg::lfsr_t h;
    ram_test_pkg::lfsr_t l;
    int                  i;
    a = ram_test_pkg::ADDR_SEED;
    h = ram_test_pkg::DATA_SEED_HI;
    l = ram_test_pkg::DATA_SEED_LO;
    for (i = 0; i < MODEL_LEN; i++) begin
      exp_addr[i] = {2'b00, a[22:0]};
      exp_word[i] = {h, l, ~h, ~l};
      a = model_step(a);
      h = model_step(h);
      l = model_step(l);
    end
  endtask

  function automatic logic [15:0] rand_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // two random bits give an ack delay of 0 to 3 cycles
  task automatic draw_delay(output int d);
    int i;
    d = 0;
    for (i = 0; i < 2; i++) begin
      rng = rand_step(rng);
      d = d * 2 + (rng[0] ? 1 : 0);
    end
  endtask

  task automatic serve_inst_port();
    ram_test_pkg::mem_data_t word;
    if (inst_req.stb) begin
      if (inst_wait < 0) begin
        draw_delay(inst_wait);
      end
      if (inst_wait > 0) begin
        inst_wait--;
      end else begin
        word = mem.exists(inst_req.addr) ? mem[inst_req.addr] : '0;
        if (inst_count == corrupt_inst_rd) begin
          word[9] = ~word[9];
        end
        inst_addr_q.push_back(inst_req.addr);
        inst_word_q.push_back(word);
        inst_count++;
        inst_rsp.rdata = word;
        inst_rsp.ack = 1'b1;
        inst_wait = -1;
      end
    end else if (inst_wait >= 0) begin
      // strobe dropped before its ack
      hold_errors++;
      inst_wait = -1;
    end
  endtask

  task automatic serve_data_port();
    ram_test_pkg::mem_data_t word;
    if (data_req.stb) begin
      if (data_wait < 0) begin
        draw_delay(data_wait);
        held = data_req;
        if (data_ops == stall_op) begin
          data_wait = 20;
          stall_seen = 1'b1;
        end
      end
      if (data_req != held) begin
        hold_errors++;
      end
      if (data_wait > 0) begin
        data_wait--;
      end else begin
        if (data_req.we) begin
          mem[data_req.addr] = data_req.wdata;
          wr_addr_q.push_back(data_req.addr);
          wr_data_q.push_back(data_req.wdata);
        end else begin
          word = mem.exists(data_req.addr) ? mem[data_req.addr] : '0;
          if (rd_count == corrupt_data_rd) begin
            word[5] = ~word[5];
          end
          rd_addr_q.push_back(data_req.addr);
          rd_count++;
          data_rsp.rdata = word;
        end
        data_ops++;
        data_rsp.ack = 1'b1;
        data_wait = -1;
      end
    end else if (data_wait >= 0) begin
      hold_errors++;
      data_wait = -1;
    end
  endtask

  // RAM responds 1 ns after the edge, acks last a single cycle
  always @(posedge clk) begin
    #1;
    inst_rsp.ack = 1'b0;
    data_rsp.ack = 1'b0;
    if (rst) begin
      mem.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      inst_addr_q.delete();
      inst_word_q.delete();
      rng = 16'd95;
      inst_wait = -1;
      data_wait = -1;
      inst_count = 0;
      rd_count = 0;
      data_ops = 0;
      hold_errors = 0;
      stall_seen = 1'b0;
    end else begin
      serve_inst_port();
      serve_data_port();
    end
  end

  task automatic check_count(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d",
               test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_word(input string what, input ram_test_pkg::mem_data_t expected,
                            input ram_test_pkg::mem_data_t actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h",
               test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // reset, run the DUT to its end and let an open instruction read finish
  task automatic run_test(input string name, input int bad_data_rd, input int bad_inst_rd,
                          input int stall_at);
    int n;
    test_name = name;
    test_start_errors = errors;
    corrupt_data_rd = bad_data_rd;
    corrupt_inst_rd = bad_inst_rd;
    stall_op = stall_at;
    apply_reset();
    n = 0;
    while (!test_ended && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!test_ended) begin
      $display("%s: timed out waiting for test_ended", name);
      errors++;
    end
    n = 0;
    while (inst_req.stb && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (inst_req.stb) begin
      $display("%s: instruction read never acknowledged after the end", name);
      errors++;
    end
    check_count("hold violations", 0, hold_errors);
  endtask

  task automatic end_test();
    if (errors == test_start_errors) begin
      $display("%s: ok", test_name);
      tests_ok++;
    end else begin
      $display("%s: %0d check(s) failed", test_name, errors - test_start_errors);
      tests_bad++;
    end
  endtask

  task automatic clean_run();
    run_test("clean_run", -1, -1, -1);
    check_count("data acknowledges", 1023, data_ops);
    check_count("data writes", 768, wr_addr_q.size());
    check_count("test_error", 0, int'(test_error));
    end_test();
  endtask

  task automatic address_sequence();
    int i;
    run_test("address_sequence", -1, -1, -1);
    check_count("data writes", 768, wr_addr_q.size());
    check_count("data reads", 255, rd_addr_q.size());
    for (i = 0; i < wr_addr_q.size() && i < MODEL_LEN && errors == test_start_errors; i++) begin
      check_word($sformatf("write address %0d", i), 128'(exp_addr[i]), 128'(wr_addr_q[i]));
      check_word($sformatf("write data %0d", i), exp_word[i], wr_data_q[i]);
    end
    for (i = 0; i < rd_addr_q.size() && i < MODEL_LEN && errors == test_start_errors; i++) begin
      check_word($sformatf("read address %0d", i), 128'(exp_addr[i]), 128'(rd_addr_q[i]));
    end
    end_test();
  endtask

  task automatic inst_sequence();
    int i;
    run_test("inst_sequence", -1, -1, -1);
    if (inst_addr_q.size() == 0) begin
      $display("inst_sequence: no instruction read was acknowledged");
      errors++;
    end
    for (i = 0; i < inst_addr_q.size() && i < MODEL_LEN && errors == test_start_errors; i++) begin
      check_word($sformatf("inst address %0d", i), 128'(exp_addr[i]), 128'(inst_addr_q[i]));
      check_word($sformatf("inst word %0d", i), exp_word[i], inst_word_q[i]);
    end
    check_count("test_error", 0, int'(test_error));
    end_test();
  endtask

  task automatic data_corruption();
    run_test("data_corruption", 4, -1, -1);
    check_count("data acknowledges", 1023, data_ops);
    check_count("test_error", 1, int'(test_error));
    end_test();
  endtask

  task automatic inst_corruption();
    run_test("inst_corruption", -1, 2, -1);
    check_count("test_error", 1, int'(test_error));
    check_count("data_error", 0, int'(i_ram_test_top.i_data_rw_path.data_error));
    end_test();
  endtask

  task automatic hold_under_stall();
    run_test("hold_under_stall", -1, -1, 10);
    if (!stall_seen) begin
      $display("hold_under_stall: the stalled data request never occurred");
      errors++;
    end
    check_count("data acknowledges", 1023, data_ops);
    check_count("data writes", 768, wr_addr_q.size());
    check_count("test_error", 0, int'(test_error));
    end_test();
  endtask

  initial begin
    rst = 1'b1;
    inst_rsp = '0;
    data_rsp = '0;
    corrupt_data_rd = -1;
    corrupt_inst_rd = -1;
    stall_op = -1;
    build_model();
    clean_run();
    address_sequence();
    inst_sequence();
    data_corruption();
    inst_corruption();
    hold_under_stall();
    $display("tests %0d, ok %0d, with errors %0d, failed checks %0d",
             tests_ok + tests_bad, tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
ram_test_pkg.sv
adr_data_gen.sv
ram_test_ctrl.sv
inst_read_path.sv
data_rw_path.sv
ram_test_top.sv
ram_test_checker.sv
tb_ram_test.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ram_test
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
	  echo "simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
